// ==== gb_io_config.svh ====
/*
 * Build constants for the console I/O glue.
 * Include in any module that needs addresses, RAM sizes or serial timing.
 */
`ifndef GB_IO_CONFIG_SVH
`define GB_IO_CONFIG_SVH

// --------------------------------------------------
// serial port timing
`define GB_SERIAL_BIT_CYCLES 512       // clk_cpu cycles per shifted bit (8192 Hz)

// --------------------------------------------------
// internal memories
`define GB_WRAM_ADDR_W     15          // 32 KiB work ram, 8 banks of 4 KiB
`define GB_ZP_ADDR_W       7           // 127 byte zero page
`define GB_WRAM_BANK_RESET 1           // svbk after reset

// --------------------------------------------------
// io register addresses
`define GB_ADDR_JOYP 16'hFF00          // p1
`define GB_ADDR_SB   16'hFF01          // serial data, dummy
`define GB_ADDR_SC   16'hFF02          // serial control
`define GB_ADDR_IF   16'hFF0F
`define GB_ADDR_SVBK 16'hFF70          // cgb wram bank
`define GB_ADDR_IE   16'hFFFF

// interrupt vectors
`define GB_IRQ_VEC_BASE 8'h40          // vblank entry
`define GB_IRQ_VEC_STEP 8'd8           // spacing between entries
`define GB_IRQ_VEC_NONE 8'h55          // nothing pending

`endif

// ==== gb_io_pkg.sv ====
/*
 * Shared types for the I/O glue: bus payloads, region codes,
 * interrupt bit layout and the two decodings of a written io byte.
 */
package gb_io_pkg;

	// cpu side request payload, valid/ready handshake around it
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;     // 1 write, 0 read
	} bus_req_t;

	// cartridge port payload, same layout as the cpu request
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
	} cart_req_t;

	// decoded target of an access
	typedef enum logic [3:0] {
		RGN_ROM,    // $0000-$7fff cart rom
		RGN_CRAM,   // $a000-$bfff cart ram
		RGN_WRAM,   // $c000-$dfff
		RGN_ZPRAM,  // $ff80-$fffe
		RGN_JOYP,
		RGN_SB,
		RGN_SC,
		RGN_IF,
		RGN_IE,
		RGN_SVBK,
		RGN_NONE    // dropped space, reads $ff
	} region_e;

	// matches the IF / IE bit order, vblank in bit 0
	typedef struct packed {
		logic joypad;   // bit 4, lowest priority
		logic serial;
		logic timer;
		logic lcd;
		logic vblank;   // bit 0
	} irq_t;

	typedef struct packed {
		logic       start;      // bit 7, transfer running
		logic [5:0] unused;
		logic       shift_clk;  // bit 0, internal clock
	} sc_view_t;

	typedef struct packed {
		logic [1:0] unused_hi;
		logic [1:0] sel;        // bits 5:4, row selects, active low
		logic [3:0] unused_lo;
	} joyp_view_t;

	// written byte as seen by the serial and joypad units
	typedef union packed {
		logic [7:0] raw;
		sc_view_t   sc_view;
		joyp_view_t joyp_view;
	} io_byte_u;

endpackage

// ==== bus_decoder.sv ====
/*
 * Cpu bus front end. Decodes each request, forwards cartridge accesses
 * with back-pressure, strobes the io registers and returns read data.
 */
`timescale 1ns/1ps
`include "gb_io_config.svh"

module bus_decoder (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_io_pkg::bus_req_t  req,
	input  logic                 req_valid,
	output logic                 req_ready,
	output logic                 rsp_valid,
	output logic [7:0]           rsp_rdata,
	output gb_io_pkg::cart_req_t cart_req,
	output logic                 cart_valid,
	input  logic                 cart_ready,
	input  logic                 cart_rsp_valid,
	input  logic [7:0]           cart_rdata,
	output gb_io_pkg::region_e   region,
	output logic                 ram_rd,
	output logic                 ram_wr,
	input  logic [7:0]           ram_rdata,
	input  logic [7:0]           svbk_rdata,
	output logic                 joyp_wr,
	output logic                 sc_wr,
	output logic                 if_wr,
	output logic                 ie_wr,
	output logic                 svbk_wr,
	output gb_io_pkg::io_byte_u  wdata,
	input  logic [7:0]           joyp_rdata,
	input  logic [7:0]           sc_rdata,
	input  logic [7:0]           if_rdata,
	input  logic [7:0]           ie_rdata
);
	import gb_io_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_CREQ, S_CWAIT} state_e;

	state_e     state;
	region_e    rd_rgn_q;    // where the pending read comes from
	logic       xfer, is_cart, is_ram, int_rd, cart_done;
	logic       rd_open;     // read accepted, response not yet given
	logic [7:0] reg_rdata, data_q;

	// --------------------------------------------------
	// address decode
	always_comb begin
		if (!req.addr[15])                   region = RGN_ROM;
		else if (req.addr[15:13] == 3'b101)  region = RGN_CRAM;
		else if (req.addr[15:13] == 3'b110)  region = RGN_WRAM;   // no echo
		else if (req.addr == `GB_ADDR_IE)    region = RGN_IE;     // before zp, same page
		else if (req.addr[15:7] == 9'h1FF)   region = RGN_ZPRAM;
		else if (req.addr == `GB_ADDR_JOYP)  region = RGN_JOYP;
		else if (req.addr == `GB_ADDR_SB)    region = RGN_SB;
		else if (req.addr == `GB_ADDR_SC)    region = RGN_SC;
		else if (req.addr == `GB_ADDR_IF)    region = RGN_IF;
		else if (req.addr == `GB_ADDR_SVBK)  region = RGN_SVBK;
		else                                 region = RGN_NONE;
	end

	assign xfer    = req_valid && req_ready;
	assign is_cart = (region == RGN_ROM) || (region == RGN_CRAM);
	assign is_ram  = (region == RGN_WRAM) || (region == RGN_ZPRAM);
	assign int_rd  = xfer && !req.wr && !is_cart;
	assign cart_done = (state == S_CWAIT) && cart_rsp_valid;

	// strobes, all on the transfer edge
	assign ram_rd  = xfer && !req.wr && is_ram;
	assign ram_wr  = xfer && req.wr && is_ram;
	assign joyp_wr = xfer && req.wr && (region == RGN_JOYP);
	assign sc_wr   = xfer && req.wr && (region == RGN_SC);
	assign if_wr   = xfer && req.wr && (region == RGN_IF);
	assign ie_wr   = xfer && req.wr && (region == RGN_IE);
	assign svbk_wr = xfer && req.wr && (region == RGN_SVBK);
	assign wdata.raw = req.wdata;

	always_comb begin
		case (region)
			RGN_JOYP: reg_rdata = joyp_rdata;
			RGN_SC:   reg_rdata = sc_rdata;
			RGN_IF:   reg_rdata = if_rdata;
			RGN_IE:   reg_rdata = ie_rdata;
			RGN_SVBK: reg_rdata = svbk_rdata;
			default:  reg_rdata = 8'hFF;      // sb and unmapped
		endcase
	end

	// --------------------------------------------------
	// cartridge fsm, one access in flight
	assign req_ready  = (state == S_IDLE);
	assign cart_valid = (state == S_CREQ);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state     <= S_IDLE;
			rsp_valid <= 1'b0;
			rd_open   <= 1'b0;
		end else begin
			rsp_valid <= int_rd || cart_done;
			if (xfer && !req.wr)
				rd_open <= 1'b1;
			else if (rsp_valid)
				rd_open <= 1'b0;      // response handed out
			case (state)
				S_IDLE:  if (xfer && is_cart) state <= S_CREQ;
				S_CREQ:  if (cart_ready) state <= cart_req.wr ? S_IDLE : S_CWAIT;
				S_CWAIT: if (cart_rsp_valid) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (xfer && is_cart)
			cart_req <= '{addr: req.addr, wdata: req.wdata, wr: req.wr};
		if (xfer && !req.wr)
			rd_rgn_q <= region;
		if (int_rd)
			data_q <= reg_rdata;       // register value at the transfer edge
		else if (cart_done)
			data_q <= cart_rdata;
	end

	// ram data arrives a cycle late from internal_ram
	assign rsp_rdata = (rd_rgn_q == RGN_WRAM || rd_rgn_q == RGN_ZPRAM) ? ram_rdata : data_q;

	a_cart_hold: assert property (@(posedge clk_cpu) disable iff (reset)
		cart_valid && !cart_ready |=> $stable(cart_req));
	a_rsp_has_read: assert property (@(posedge clk_cpu) disable iff (reset)
		rsp_valid |-> rd_open);

endmodule

// ==== internal_ram.sv ====
/*
 * Work ram with cgb bank switching through svbk, and zero page ram.
 * Both read synchronously into one output register.
 */
`timescale 1ns/1ps
`include "gb_io_config.svh"

module internal_ram (
	input  logic                clk_cpu,
	input  logic                reset,
	input  logic                cgb_mode,
	input  gb_io_pkg::region_e  region,
	input  logic [15:0]         addr,
	input  logic                ram_rd,
	input  logic                ram_wr,
	input  logic [7:0]          wdata,
	input  logic                svbk_wr,
	output logic [7:0]          ram_rdata,
	output logic [7:0]          svbk_rdata
);
	import gb_io_pkg::*;

	localparam int WRAM_DEPTH = 1 << `GB_WRAM_ADDR_W;
	localparam int ZP_DEPTH   = (1 << `GB_ZP_ADDR_W) - 1;   // $ff80-$fffe

	logic [7:0] wram [WRAM_DEPTH];
	logic [7:0] zpram [ZP_DEPTH];

	logic [2:0]                   bank;
	logic [`GB_WRAM_ADDR_W-1:0]   wram_addr;
	logic [`GB_ZP_ADDR_W-1:0]     zp_addr;

	// $d000-$dfff goes through svbk, $c000-$cfff is fixed bank 0
	assign wram_addr = addr[12] ? {bank, addr[11:0]} : {3'd0, addr[11:0]};
	assign zp_addr   = addr[6:0];

	always_ff @(posedge clk_cpu) begin
		if (ram_wr && region == RGN_WRAM)
			wram[wram_addr] <= wdata;
		if (ram_wr && region == RGN_ZPRAM)
			zpram[zp_addr] <= wdata;
		if (ram_rd)
			ram_rdata <= (region == RGN_ZPRAM) ? zpram[zp_addr] : wram[wram_addr];
	end

	// --------------------------------------------------
	// svbk, cgb only
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= 3'(`GB_WRAM_BANK_RESET);
		else if (svbk_wr && cgb_mode)
			bank <= (wdata[2:0] == 3'd0) ? 3'd1 : wdata[2:0];   // bank 0 aliases 1
	end

	assign svbk_rdata = {5'h1F, bank};

endmodule

// ==== interrupt_ctrl.sv ====
/*
 * IF and IE registers with event capture and prioritised acknowledge.
 * irq_vector always points at the entry the next ack would take.
 */
`timescale 1ns/1ps
`include "gb_io_config.svh"

module interrupt_ctrl (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_io_pkg::irq_t  events,
	input  logic             if_wr,
	input  logic             ie_wr,
	input  logic [7:0]       wdata,
	output logic [7:0]       if_rdata,
	output logic [7:0]       ie_rdata,
	output logic             irq_pending,
	input  logic             irq_ack,
	output logic [7:0]       irq_vector
);
	logic [4:0] if_q, ie_q;
	logic [4:0] ev, active, ack_mask;
	logic [2:0] ack_idx;
	logic       any_active;

	assign ev     = events;
	assign active = if_q & ie_q;

	// lowest set bit wins, vblank first
	always_comb begin
		ack_idx    = 3'd0;
		any_active = 1'b0;
		for (int i = 4; i >= 0; i--) begin
			if (active[i]) begin
				ack_idx    = 3'(i);
				any_active = 1'b1;
			end
		end
	end

	assign ack_mask    = (irq_ack && any_active) ? (5'b00001 << ack_idx) : 5'b00000;
	assign irq_pending = any_active;
	assign irq_vector  = any_active ? 8'(`GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * ack_idx)
		: `GB_IRQ_VEC_NONE;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_q <= 5'b0;
			ie_q <= 5'b0;
		end else begin
			if (if_wr)
				if_q <= wdata[4:0];                 // cpu write overrides all
			else
				if_q <= (if_q & ~ack_mask) | ev;    // a new event survives its own ack
			if (ie_wr)
				ie_q <= wdata[4:0];
		end
	end

	assign if_rdata = {3'b111, if_q};
	assign ie_rdata = {3'b000, ie_q};

	a_ack_pending: assert property (@(posedge clk_cpu) disable iff (reset)
		irq_ack |-> irq_pending);

endmodule

// ==== joypad.sv ====
/*
 * P1 joypad register. Two active low row selects over the 8 key matrix,
 * pressed keys read as 0. Any falling row line raises joy_irq.
 */
`timescale 1ns/1ps

module joypad (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  logic [7:0]           joystick,   // 1 = pressed
	input  logic                 joyp_wr,
	input  gb_io_pkg::io_byte_u  wdata,
	output logic [7:0]           joyp_rdata,
	output logic                 joy_irq
);
	logic [1:0] sel_q;
	logic [3:0] row_dir, row_btn;
	logic [7:0] lines_q, lines_qq;   // two stage sample for edge detect

	// deselected row floats high
	assign row_dir = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{sel_q[0]}};
	assign row_btn = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{sel_q[1]}};

	assign joyp_rdata = {2'b11, sel_q, row_dir & row_btn};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel_q    <= 2'b00;
			lines_q  <= 8'hFF;
			lines_qq <= 8'hFF;
		end else begin
			if (joyp_wr)
				sel_q <= wdata.joyp_view.sel;
			lines_q  <= {row_dir, row_btn};
			lines_qq <= lines_q;
		end
	end

	assign joy_irq = |(lines_qq & ~lines_q);   // high to low on any line

endmodule

// ==== serial_port.sv ====
/*
 * Dummy serial port. A transfer with internal clock runs 8 bit times,
 * then raises serial_irq and drops the start bit. No data is shifted.
 */
`timescale 1ns/1ps
`include "gb_io_config.svh"

module serial_port #(
	parameter int BIT_CYCLES = `GB_SERIAL_BIT_CYCLES
) (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  logic                 sc_wr,
	input  gb_io_pkg::io_byte_u  wdata,
	output logic [7:0]           sc_rdata,
	output logic                 serial_irq
);
	localparam int DIV_W = $clog2(BIT_CYCLES + 1);

	logic             start_q, shift_clk_q;
	logic [DIV_W-1:0] div_q;          // cycles within one bit
	logic [3:0]       bit_cnt;        // bits done
	logic             bit_tick;

	assign bit_tick = (div_q == DIV_W'(BIT_CYCLES - 1));

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			start_q     <= 1'b0;
			shift_clk_q <= 1'b0;
			div_q       <= '0;
			bit_cnt     <= 4'd0;
			serial_irq  <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_wr) begin
				start_q     <= wdata.sc_view.start;
				shift_clk_q <= wdata.sc_view.shift_clk;
				div_q       <= '0;
				bit_cnt     <= 4'd0;
			end else if (start_q && shift_clk_q) begin   // external clock never runs
				if (bit_cnt == 4'd8) begin
					serial_irq <= 1'b1;
					start_q    <= 1'b0;
					bit_cnt    <= 4'd0;
				end else if (bit_tick) begin
					div_q   <= '0;
					bit_cnt <= bit_cnt + 4'd1;
				end else begin
					div_q <= div_q + DIV_W'(1);
				end
			end
		end
	end

	assign sc_rdata = {start_q, 6'h3F, shift_clk_q};

	a_bit_cnt: assert property (@(posedge clk_cpu) disable iff (reset) bit_cnt <= 4'd8);

endmodule

// ==== gb_io_top.sv ====
/*
 * Memory-map glue around a cpu side valid/ready bus.
 * Ties the decoder to ram, joypad, serial port and interrupt controller.
 */
`timescale 1ns/1ps
`include "gb_io_config.svh"

module gb_io_top #(
	parameter int SERIAL_BIT_CYCLES = `GB_SERIAL_BIT_CYCLES
) (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  logic                 cgb_mode,
	input  logic [7:0]           joystick,
	input  logic [2:0]           ext_irq,        // timer, lcd, vblank
	input  gb_io_pkg::bus_req_t  req,
	input  logic                 req_valid,
	output logic                 req_ready,
	output logic                 rsp_valid,
	output logic [7:0]           rsp_rdata,
	output gb_io_pkg::cart_req_t cart_req,
	output logic                 cart_valid,
	input  logic                 cart_ready,
	input  logic                 cart_rsp_valid,
	input  logic [7:0]           cart_rdata,
	output logic                 irq_pending,
	input  logic                 irq_ack,
	output logic [7:0]           irq_vector
);
	import gb_io_pkg::*;

	region_e    region;
	io_byte_u   wdata;
	irq_t       events;
	logic       ram_rd, ram_wr;
	logic       joyp_wr, sc_wr, if_wr, ie_wr, svbk_wr;
	logic [7:0] ram_rdata, svbk_rdata;
	logic [7:0] joyp_rdata, sc_rdata, if_rdata, ie_rdata;
	logic       joy_irq, serial_irq;

	// external events plus the two local sources
	assign events = '{joypad: joy_irq, serial: serial_irq, timer: ext_irq[2],
		lcd: ext_irq[1], vblank: ext_irq[0]};

	bus_decoder u_dec (
		.clk_cpu(clk_cpu), .reset(reset),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
		.cart_req(cart_req), .cart_valid(cart_valid), .cart_ready(cart_ready),
		.cart_rsp_valid(cart_rsp_valid), .cart_rdata(cart_rdata),
		.region(region), .ram_rd(ram_rd), .ram_wr(ram_wr),
		.ram_rdata(ram_rdata), .svbk_rdata(svbk_rdata),
		.joyp_wr(joyp_wr), .sc_wr(sc_wr), .if_wr(if_wr), .ie_wr(ie_wr),
		.svbk_wr(svbk_wr), .wdata(wdata),
		.joyp_rdata(joyp_rdata), .sc_rdata(sc_rdata),
		.if_rdata(if_rdata), .ie_rdata(ie_rdata)
	);

	internal_ram u_ram (
		.clk_cpu(clk_cpu), .reset(reset), .cgb_mode(cgb_mode),
		.region(region), .addr(req.addr), .ram_rd(ram_rd), .ram_wr(ram_wr),
		.wdata(wdata.raw), .svbk_wr(svbk_wr),
		.ram_rdata(ram_rdata), .svbk_rdata(svbk_rdata)
	);

	interrupt_ctrl u_irq (
		.clk_cpu(clk_cpu), .reset(reset), .events(events),
		.if_wr(if_wr), .ie_wr(ie_wr), .wdata(wdata.raw),
		.if_rdata(if_rdata), .ie_rdata(ie_rdata),
		.irq_pending(irq_pending), .irq_ack(irq_ack), .irq_vector(irq_vector)
	);

	joypad u_joy (
		.clk_cpu(clk_cpu), .reset(reset), .joystick(joystick),
		.joyp_wr(joyp_wr), .wdata(wdata),
		.joyp_rdata(joyp_rdata), .joy_irq(joy_irq)
	);

	serial_port #(.BIT_CYCLES(SERIAL_BIT_CYCLES)) u_ser (
		.clk_cpu(clk_cpu), .reset(reset), .sc_wr(sc_wr), .wdata(wdata),
		.sc_rdata(sc_rdata), .serial_irq(serial_irq)
	);

endmodule

// ==== tb_gb_io.sv ====
/*
 * Testbench for gb_io_top. Acts as the cpu on the valid/ready bus and as
 * the cartridge behind it, and checks every read against a shadow model.
 */
`timescale 1ns/1ps
`include "gb_io_config.svh"

module tb_gb_io;
	import gb_io_pkg::*;

	localparam int SER_BIT      = 4;                      // short serial bit time
	localparam int N_RAND       = 300;
	localparam int N_JOY        = 32;
	localparam int N_OPS        = N_RAND + 2 * N_JOY + 80; // plus directed accesses
	localparam int WATCH_CYCLES = N_OPS * 20 + 8 * SER_BIT + 40;

	logic       clk_cpu, reset, cgb_mode;
	logic [7:0] joystick, rsp_rdata, cart_rdata, irq_vector;
	logic [2:0] ext_irq;                                  // timer, lcd, vblank
	bus_req_t   req;
	cart_req_t  cart_req;
	logic       req_valid, req_ready, rsp_valid;
	logic       cart_valid, cart_ready, cart_rsp_valid;
	logic       irq_pending, irq_ack;

	// shadow model of everything the cpu can see
	logic [7:0] cart_mem [65536];   // the cartridge itself
	logic [7:0] cart_sh [65536];
	logic [7:0] wram_sh [32768];
	logic [7:0] zp_sh [127];
	bit         ram_seen [65536];   // ram addresses written at least once
	logic [2:0] bank_sh;
	logic [1:0] sel_sh;
	logic       sc_start_sh, sc_clk_sh;
	logic [4:0] if_sh, ie_sh;
	logic [7:0] exp_q [$];          // expected read data, oldest first

	gb_io_top #(.SERIAL_BIT_CYCLES(SER_BIT)) dut_i (.*);

	always #10 clk_cpu = ~clk_cpu;

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
			$display("=== FAIL ===");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("error: %s at %0t", why, $time);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_cpu);
		#1;                             // back to the drive point
	endtask

	// --------------------------------------------------
	// reference model
	function automatic logic [14:0] wram_index(input logic [15:0] a);
		return a[12] ? {bank_sh, a[11:0]} : {3'd0, a[11:0]};   // $c000 page is bank 0
	endfunction

	function automatic bit is_cart(input logic [15:0] a);
		return (a < 16'h8000) || (a >= 16'hA000 && a < 16'hC000);
	endfunction

	function automatic bit is_ram(input logic [15:0] a);
		return (a[15:13] == 3'b110) || (a >= 16'hFF80 && a != 16'hFFFF);
	endfunction

	// vector table, vblank entry at $40 and 8 bytes apart
	function automatic logic [7:0] expected_vector(input int idx);
		case (idx)
			0:       return 8'h40;
			1:       return 8'h48;
			2:       return 8'h50;
			3:       return 8'h58;
			4:       return 8'h60;
			default: return 8'h55;          // nothing pending
		endcase
	endfunction

	function automatic logic [7:0] ref_read(input logic [15:0] a);
		logic [3:0] keys;
		if (is_cart(a))
			return cart_sh[a];
		if (a[15:13] == 3'b110)
			return wram_sh[wram_index(a)];
		if (a >= 16'hFF80 && a != 16'hFFFF)
			return zp_sh[7'(a - 16'hFF80)];
		case (a)
			`GB_ADDR_JOYP: begin
				keys = 4'hF;                  // released keys read high
				if (!sel_sh[0])
					keys = keys & ~{joystick[2], joystick[3], joystick[1], joystick[0]};
				if (!sel_sh[1])
					keys = keys & ~joystick[7:4];
				return {2'b11, sel_sh, keys};
			end
			`GB_ADDR_SC:   return {sc_start_sh, 6'h3F, sc_clk_sh};
			`GB_ADDR_IF:   return {3'b111, if_sh};
			`GB_ADDR_IE:   return {3'b000, ie_sh};
			`GB_ADDR_SVBK: return {5'h1F, bank_sh};
			default:       return 8'hFF;  // sb and dropped space
		endcase
	endfunction

	function automatic void shadow_write(input logic [15:0] a, input logic [7:0] d);
		if (is_cart(a))
			cart_sh[a] = d;             // rom writes reach the cartridge too
		else if (a[15:13] == 3'b110)
			wram_sh[wram_index(a)] = d;
		else if (a >= 16'hFF80 && a != 16'hFFFF)
			zp_sh[7'(a - 16'hFF80)] = d;
		else case (a)
			`GB_ADDR_JOYP: sel_sh = d[5:4];
			`GB_ADDR_SC: begin
				sc_start_sh = d[7];
				sc_clk_sh   = d[0];
			end
			`GB_ADDR_IF:   if_sh = d[4:0];
			`GB_ADDR_IE:   ie_sh = d[4:0];
			`GB_ADDR_SVBK: if (cgb_mode) bank_sh = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
			default: ;                    // ignored
		endcase
		if (is_ram(a))
			ram_seen[a] = 1'b1;
	endfunction

	function automatic logic [15:0] random_addr();
		logic [15:0] r;
		r = 16'($urandom);
		case ($urandom_range(4, 0))
			0: return {1'b0, r[14:0]};                       // rom
			1: return {3'b101, r[12:0]};                     // cart ram
			2: return {3'b110, r[12:0]};                     // wram
			3: return 16'hFF80 + 16'($urandom_range(126, 0));
			default: return r[0] ? {3'b100, r[12:0]} : 16'hFF10 + 16'(r[5:0]); // vram, audio
		endcase
	endfunction

	// --------------------------------------------------
	// cpu bus driver
	task automatic bus_start(input logic [15:0] a, input logic [7:0] d, input logic wr);
		req = '{addr: a, wdata: d, wr: wr};
		req_valid = 1'b1;
		do @(negedge clk_cpu); while (!req_ready);   // ready seen, next edge transfers
		@(posedge clk_cpu);
		#1 req_valid = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		shadow_write(a, d);
		bus_start(a, d, 1'b1);
	endtask

	task automatic bus_read(input logic [15:0] a);
		exp_q.push_back(ref_read(a));
		bus_start(a, 8'h00, 1'b0);
		do @(negedge clk_cpu); while (!rsp_valid);
		idle_cycles(1);
	endtask

	// response compare
	always @(negedge clk_cpu) begin
		if (!reset && rsp_valid) begin
			if (exp_q.size() == 0)
				abort_run("read response arrived with no read outstanding");
			else
				check_value("rsp_rdata", rsp_rdata, exp_q.pop_front());
		end
	end

	// cartridge, random ready and data latency
	initial begin : cart_model
		cart_req_t creq;
		int        n;
		forever begin
			@(posedge clk_cpu);
			#1;
			if (!reset && cart_valid) begin
				creq = cart_req;
				n = $urandom_range(3, 0);
				repeat (n) idle_cycles(1);
				cart_ready = 1'b1;
				idle_cycles(1);             // request taken on this edge
				cart_ready = 1'b0;
				if (creq.wr) begin
					cart_mem[creq.addr] = creq.wdata;
				end else begin
					n = $urandom_range(3, 1);
					repeat (n - 1) idle_cycles(1);
					cart_rdata     = cart_mem[creq.addr];
					cart_rsp_valid = 1'b1;
					idle_cycles(1);
					cart_rsp_valid = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCH_CYCLES) @(posedge clk_cpu);
		abort_run("simulation timed out, a bus access or transfer never finished");
	end

	// --------------------------------------------------
	// test sequence
	initial begin
		int unsigned seed_ret;
		logic [15:0] a;
		logic [4:0]  act;
		int          idx;
		seed_ret       = $urandom(32'h13f9_acc6);
		clk_cpu        = 1'b0;
		reset          = 1'b1;
		cgb_mode       = 1'b1;
		joystick       = 8'h00;       // nothing pressed, no edge out of reset
		ext_irq        = 3'b000;
		req            = '0;
		req_valid      = 1'b0;
		cart_ready     = 1'b0;
		cart_rsp_valid = 1'b0;
		cart_rdata     = 8'h00;
		irq_ack        = 1'b0;
		for (int i = 0; i < 65536; i++) begin
			cart_mem[16'(i)] = 8'(i ^ (i >> 8)) ^ 8'h5A;
			cart_sh[16'(i)]  = cart_mem[16'(i)];
			ram_seen[16'(i)] = 1'b0;
		end
		bank_sh     = 3'(`GB_WRAM_BANK_RESET);
		sel_sh      = 2'b00;
		sc_start_sh = 1'b0;
		sc_clk_sh   = 1'b0;
		if_sh       = 5'd0;
		ie_sh       = 5'd0;
		repeat (4) @(posedge clk_cpu);
		#1 reset = 1'b0;
		check_value("idle outputs", {4'd0, req_ready, rsp_valid, cart_valid, irq_pending}, 8'h08);

		// random traffic, ram read only where written before
		for (int i = 0; i < N_RAND; i++) begin
			a = random_addr();
			if ($urandom_range(1, 0) == 1 || (is_ram(a) && !ram_seen[a]))
				bus_write(a, 8'($urandom));
			else
				bus_read(a);
		end

		// svbk banking
		for (int b = 1; b < 8; b++) begin
			bus_write(`GB_ADDR_SVBK, 8'(b));
			bus_write(16'hD123, 8'hA0 + 8'(b));
		end
		bus_write(16'hC123, 8'h3C);
		for (int b = 7; b > 0; b--) begin
			bus_write(`GB_ADDR_SVBK, 8'(b));
			bus_read(`GB_ADDR_SVBK);
			bus_read(16'hD123);
			bus_read(16'hC123);
		end
		bus_write(`GB_ADDR_SVBK, 8'h00);   // maps to bank 1
		bus_read(`GB_ADDR_SVBK);
		cgb_mode = 1'b0;
		bus_write(`GB_ADDR_SVBK, 8'h05);   // dmg mode, no effect
		bus_read(`GB_ADDR_SVBK);
		bus_read(16'hD123);
		cgb_mode = 1'b1;

		// joypad matrix
		for (int i = 0; i < N_JOY; i++) begin
			joystick = 8'($urandom);
			bus_write(`GB_ADDR_JOYP, {2'b00, 2'($urandom), 4'h0});
			bus_read(`GB_ADDR_JOYP);
		end
		joystick = 8'h00;
		bus_write(`GB_ADDR_JOYP, 8'h20);   // direction row only
		idle_cycles(4);
		bus_write(`GB_ADDR_IF, 8'h00);
		joystick = 8'h01;                  // press right
		idle_cycles(4);
		if_sh[4] = 1'b1;
		bus_read(`GB_ADDR_IF);

		// serial transfer on internal clock
		bus_write(`GB_ADDR_IF, 8'h00);
		bus_write(`GB_ADDR_SC, 8'h81);
		idle_cycles(8 * SER_BIT + 8);
		if_sh[3]    = 1'b1;
		sc_start_sh = 1'b0;
		bus_read(`GB_ADDR_IF);
		bus_read(`GB_ADDR_SC);

		// external events, then acknowledge in priority order
		bus_write(`GB_ADDR_IE, 8'h00);
		bus_write(`GB_ADDR_IF, 8'h00);
		ext_irq = 3'b111;
		idle_cycles(1);
		ext_irq = 3'b000;
		idle_cycles(2);
		if_sh = if_sh | 5'b00111;
		bus_read(`GB_ADDR_IF);
		check_value("irq_pending", 8'(irq_pending), 8'h00);
		bus_write(`GB_ADDR_IF, 8'h1F);
		bus_write(`GB_ADDR_IE, 8'h1D);     // lcd stays masked
		act = if_sh & ie_sh;
		while (act != 5'd0) begin
			idx = 0;
			while (!act[3'(idx)])
				idx++;
			check_value("irq_pending", 8'(irq_pending), 8'h01);
			check_value("irq_vector", irq_vector, expected_vector(idx));
			irq_ack = 1'b1;
			idle_cycles(1);
			irq_ack = 1'b0;
			if_sh[3'(idx)] = 1'b0;
			bus_read(`GB_ADDR_IF);         // only that bit gone
			act = if_sh & ie_sh;
		end
		check_value("irq_pending", 8'(irq_pending), 8'h00);
		check_value("irq_vector", irq_vector, expected_vector(-1));   // none pending

		idle_cycles(4);
		if (exp_q.size() != 0) begin
			abort_run("read responses still missing at the end of the test");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// ==== compile.f ====
+incdir+.
gb_io_pkg.sv
bus_decoder.sv
internal_ram.sv
interrupt_ctrl.sv
joypad.sv
serial_port.sv
gb_io_top.sv
tb_gb_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failure.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_gb_io -f compile.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without failure"
